//--- design/island_pkg.sv
// ---------------------------------------------------------------------
// Shared definitions for the safety island memory fabric: address map,
// request and response payloads of the req/gnt/rvalid bus, target
// encodings and the constant boot ROM image.
// ---------------------------------------------------------------------

`default_nettype none

package island_pkg;

  localparam int unsigned addr_width = 32;
  localparam int unsigned data_width = 32;
  localparam int unsigned be_width   = data_width / 8;

  // ---------------------------------------------------------------------
  // Address map
  // ---------------------------------------------------------------------
  localparam int unsigned bank_num_bytes = 1024;
  localparam int unsigned bank_num_words = bank_num_bytes / be_width;
  localparam int unsigned bank_word_bits = $clog2(bank_num_words);

  localparam logic [addr_width-1:0] bank0_base  = 32'h0000_0000;
  localparam logic [addr_width-1:0] bank1_base  = bank0_base + bank_num_bytes;
  localparam logic [addr_width-1:0] periph_base = 32'h0020_0000;

  localparam logic [addr_width-1:0] soc_ctrl_offset = 32'h0000_0000;
  localparam logic [addr_width-1:0] soc_ctrl_range  = 32'h0000_1000;
  localparam logic [addr_width-1:0] boot_rom_offset = 32'h0000_1000;
  localparam logic [addr_width-1:0] boot_rom_range  = 32'h0000_1000;

  localparam logic [addr_width-1:0] boot_addr_default = periph_base + boot_rom_offset + 32'h80;
  localparam logic [data_width-1:0] error_rdata       = 32'hBADC_AB1E;

  // Register offsets inside the SoC control window
  localparam logic [addr_width-1:0] reg_bootaddr_off = 32'h0;
  localparam logic [addr_width-1:0] reg_fetchen_off  = 32'h4;
  localparam logic [addr_width-1:0] reg_bootmode_off = 32'h8;

  // Boot image repeated over the whole ROM window
  localparam logic [0:7][data_width-1:0] boot_rom_words = {
    32'h0000_0297, 32'h0202_8293, 32'h3052_9073, 32'h0010_0093,
    32'h0000_0013, 32'h1050_0073, 32'hFFDF_F06F, 32'h0000_8067
  };

  // ---------------------------------------------------------------------
  // Bus payloads and encodings
  // ---------------------------------------------------------------------
  typedef struct packed {
    logic                  we;
    logic [be_width-1:0]   be;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [data_width-1:0] rdata;
    logic                  err;
  } mem_rsp_t;

  typedef enum logic [1:0] {TGT_BANK0, TGT_BANK1, TGT_PERIPH} target_e;

  typedef enum logic [1:0] {PERIPH_ERROR, PERIPH_SOC_CTRL, PERIPH_BOOT_ROM} periph_e;

  typedef enum logic [1:0] {BOOT_PASSIVE, BOOT_SERIAL, BOOT_PRELOAD} bootmode_e;

endpackage

`default_nettype wire

//--- design/island_xbar.sv
// ---------------------------------------------------------------------
// Two-manager, three-target crossbar. Each manager address is decoded
// onto bank 0, bank 1 or the peripheral port; each target is shared
// round-robin. The owner of every transfer is recorded so the response
// one cycle later returns to the manager that issued it.
// ---------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module island_xbar (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 mgr_req_i     [2],
  input  island_pkg::mem_req_t mgr_payload_i [2],
  output logic                 mgr_gnt_o     [2],
  output logic                 mgr_rvalid_o  [2],
  output island_pkg::mem_rsp_t mgr_rsp_o     [2],
  output logic                 tgt_req_o     [3],
  output island_pkg::mem_req_t tgt_payload_o [3],
  input  logic                 tgt_gnt_i     [3],
  input  logic                 tgt_rvalid_i  [3],
  input  island_pkg::mem_rsp_t tgt_rsp_i     [3]
);

  island_pkg::target_e mgr_tgt [2];
  logic [1:0]          tgt_want [3];
  logic                tgt_winner [3];
  logic                rr_q [3];
  logic                owner_q [3];

  // ---------------------------------------------------------------------
  // Address decode
  // ---------------------------------------------------------------------
  always_comb begin
    for (int m = 0; m < 2; m++) begin
      if (mgr_payload_i[m].addr >= island_pkg::bank0_base &&
          mgr_payload_i[m].addr < island_pkg::bank0_base + island_pkg::bank_num_bytes) begin
        mgr_tgt[m] = island_pkg::TGT_BANK0;
      end else if (mgr_payload_i[m].addr >= island_pkg::bank1_base &&
                   mgr_payload_i[m].addr <
                   island_pkg::bank1_base + island_pkg::bank_num_bytes) begin
        mgr_tgt[m] = island_pkg::TGT_BANK1;
      end else begin
        // Anything unmapped ends at the error responder behind the port
        mgr_tgt[m] = island_pkg::TGT_PERIPH;
      end
    end
  end

  // ---------------------------------------------------------------------
  // Arbitration and request routing
  // ---------------------------------------------------------------------
  always_comb begin
    for (int t = 0; t < 3; t++) begin
      for (int m = 0; m < 2; m++) begin
        tgt_want[t][m] = mgr_req_i[m] && (mgr_tgt[m] == island_pkg::target_e'(t));
      end
      // Pointer only matters on a collision
      if (&tgt_want[t]) begin
        tgt_winner[t] = rr_q[t];
      end else begin
        tgt_winner[t] = tgt_want[t][1];
      end
      tgt_req_o[t]     = |tgt_want[t];
      tgt_payload_o[t] = mgr_payload_i[tgt_winner[t]];
    end
  end

  // Grant goes back to the winner once its target accepts
  always_comb begin
    for (int m = 0; m < 2; m++) begin
      mgr_gnt_o[m] = 1'b0;
    end
    for (int t = 0; t < 3; t++) begin
      for (int m = 0; m < 2; m++) begin
        if (tgt_want[t][m] && tgt_winner[t] == 1'(m) && tgt_gnt_i[t]) begin
          mgr_gnt_o[m] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int t = 0; t < 3; t++) begin
        rr_q[t]    <= 1'b0;
        owner_q[t] <= 1'b0;
      end
    end else begin
      for (int t = 0; t < 3; t++) begin
        if (tgt_req_o[t] && tgt_gnt_i[t]) begin
          rr_q[t]    <= ~tgt_winner[t];
          owner_q[t] <= tgt_winner[t];
        end
      end
    end
  end

  // ---------------------------------------------------------------------
  // Response routing
  // ---------------------------------------------------------------------
  always_comb begin
    for (int m = 0; m < 2; m++) begin
      mgr_rvalid_o[m] = 1'b0;
      mgr_rsp_o[m]    = '0;
    end
    // A manager has at most one transfer per cycle, so no collision here
    for (int t = 0; t < 3; t++) begin
      if (tgt_rvalid_i[t]) begin
        mgr_rvalid_o[owner_q[t]] = 1'b1;
        mgr_rsp_o[owner_q[t]]    = tgt_rsp_i[t];
      end
    end
  end

  for (genvar t = 0; t < 3; t++) begin : gen_rsp_check
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      tgt_rvalid_i[t] |-> $past(tgt_req_o[t] && tgt_gnt_i[t]))
      else $error("target %0d responded without a transfer in the cycle before", t);
  end

endmodule

`default_nettype wire

//--- design/island_sram_bank.sv
// ---------------------------------------------------------------------
// Single-port word memory for one bank. Every request is granted at
// once; read data and rvalid follow one cycle later. Writes honour the
// byte enables and also get a response.
// ---------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module island_sram_bank (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  island_pkg::mem_req_t payload_i,
  output logic                 gnt_o,
  output logic                 rvalid_o,
  output island_pkg::mem_rsp_t rsp_o
);

  logic [island_pkg::data_width-1:0]     mem_q [island_pkg::bank_num_words];
  logic [island_pkg::data_width-1:0]     rdata_q;
  logic [island_pkg::bank_word_bits-1:0] word_idx;
  logic                                  rvalid_q;

  // Base address is dropped by keeping only the word offset
  assign word_idx = payload_i.addr[island_pkg::bank_word_bits+1:2];
  assign gnt_o    = req_i;

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (payload_i.we) begin
        for (int b = 0; b < island_pkg::be_width; b++) begin
          if (payload_i.be[b]) begin
            mem_q[word_idx][8*b +: 8] <= payload_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rvalid_o    = rvalid_q;
  assign rsp_o.rdata = rdata_q;
  assign rsp_o.err   = 1'b0;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && payload_i.we |-> payload_i.be != '0)
    else $error("write request without any byte enable");

endmodule

`default_nettype wire

//--- design/island_periph_demux.sv
// ---------------------------------------------------------------------
// Peripheral port. Decodes the address onto SoC control, the boot ROM
// or the error responder. ROM and error responder live here and always
// grant; SoC control grants for itself. The select is registered so the
// response one cycle later comes from the right source.
// ---------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module island_periph_demux (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  island_pkg::mem_req_t payload_i,
  output logic                 gnt_o,
  output logic                 rvalid_o,
  output island_pkg::mem_rsp_t rsp_o,
  output logic                 soc_req_o,
  output island_pkg::mem_req_t soc_payload_o,
  input  logic                 soc_gnt_i,
  input  logic                 soc_rvalid_i,
  input  island_pkg::mem_rsp_t soc_rsp_i
);

  island_pkg::periph_e  sel;
  island_pkg::periph_e  sel_q;
  island_pkg::mem_rsp_t local_rsp;
  island_pkg::mem_rsp_t local_rsp_q;
  logic                 local_rvalid_q;
  logic                 xfer_q;

  // ---------------------------------------------------------------------
  // Decode
  // ---------------------------------------------------------------------
  always_comb begin
    if (payload_i.addr >= island_pkg::periph_base + island_pkg::soc_ctrl_offset &&
        payload_i.addr < island_pkg::periph_base + island_pkg::soc_ctrl_offset +
                         island_pkg::soc_ctrl_range) begin
      sel = island_pkg::PERIPH_SOC_CTRL;
    end else if (payload_i.addr >= island_pkg::periph_base + island_pkg::boot_rom_offset &&
                 payload_i.addr < island_pkg::periph_base + island_pkg::boot_rom_offset +
                                  island_pkg::boot_rom_range) begin
      sel = island_pkg::PERIPH_BOOT_ROM;
    end else begin
      sel = island_pkg::PERIPH_ERROR;
    end
  end

  assign soc_req_o     = req_i && (sel == island_pkg::PERIPH_SOC_CTRL);
  assign soc_payload_o = payload_i;
  assign gnt_o         = (sel == island_pkg::PERIPH_SOC_CTRL) ? soc_gnt_i : req_i;

  // Boot ROM and error responder
  always_comb begin
    local_rsp.rdata = island_pkg::error_rdata;
    local_rsp.err   = 1'b1;
    if (sel == island_pkg::PERIPH_BOOT_ROM) begin
      // ROM image wraps every 8 words
      local_rsp.rdata = island_pkg::boot_rom_words[payload_i.addr[4:2]];
      local_rsp.err   = payload_i.we;
    end
  end

  // ---------------------------------------------------------------------
  // Response return
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      local_rsp_q <= local_rsp;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q          <= island_pkg::PERIPH_ERROR;
      local_rvalid_q <= 1'b0;
      xfer_q         <= 1'b0;
    end else begin
      sel_q          <= sel;
      local_rvalid_q <= req_i && (sel != island_pkg::PERIPH_SOC_CTRL);
      xfer_q         <= req_i && gnt_o;
    end
  end

  assign rvalid_o = (sel_q == island_pkg::PERIPH_SOC_CTRL) ? soc_rvalid_i : local_rvalid_q;
  assign rsp_o    = (sel_q == island_pkg::PERIPH_SOC_CTRL) ? soc_rsp_i : local_rsp_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni) rvalid_o |-> xfer_q)
    else $error("peripheral response without a transfer in the cycle before");

endmodule

`default_nettype wire

//--- design/island_soc_ctrl.sv
// ---------------------------------------------------------------------
// SoC control registers: boot address, fetch enable and the read-only
// boot mode. Requests are granted at once and answered one cycle later.
// Fetch enable can be taken over by a hardware pin via the selector.
// ---------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module island_soc_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              req_i,
  input  island_pkg::mem_req_t              payload_i,
  output logic                              gnt_o,
  output logic                              rvalid_o,
  output island_pkg::mem_rsp_t              rsp_o,
  input  island_pkg::bootmode_e             bootmode_i,
  input  logic                              fetch_enable_selector_i,
  input  logic                              fetch_enable_i,
  output logic                              fetch_enable_o,
  output logic [island_pkg::addr_width-1:0] boot_addr_o
);

  logic [island_pkg::addr_width-1:0] reg_off;
  logic [island_pkg::addr_width-1:0] bootaddr_q;
  logic                              fetchen_q;
  logic                              rvalid_q;
  island_pkg::mem_rsp_t              rsp_d;
  island_pkg::mem_rsp_t              rsp_q;

  assign reg_off = payload_i.addr & (island_pkg::soc_ctrl_range - 1);
  assign gnt_o   = req_i;

  always_comb begin
    rsp_d.rdata = '0;
    rsp_d.err   = 1'b0;
    case (reg_off)
      island_pkg::reg_bootaddr_off: rsp_d.rdata = bootaddr_q;
      island_pkg::reg_fetchen_off:  rsp_d.rdata = {31'b0, fetchen_q};
      island_pkg::reg_bootmode_off: begin
        rsp_d.rdata = 32'(bootmode_i);
        rsp_d.err   = payload_i.we;
      end
      default: rsp_d.err = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bootaddr_q <= island_pkg::boot_addr_default;
      fetchen_q  <= 1'b0;
      rvalid_q   <= 1'b0;
    end else begin
      rvalid_q <= req_i;
      if (req_i && payload_i.we) begin
        if (reg_off == island_pkg::reg_bootaddr_off) begin
          for (int b = 0; b < island_pkg::be_width; b++) begin
            if (payload_i.be[b]) begin
              bootaddr_q[8*b +: 8] <= payload_i.wdata[8*b +: 8];
            end
          end
        end
        if (reg_off == island_pkg::reg_fetchen_off && payload_i.be[0]) begin
          fetchen_q <= payload_i.wdata[0];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rsp_q <= rsp_d;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rsp_o    = rsp_q;

  // Hardware pin wins over the register when selected
  assign fetch_enable_o = fetch_enable_selector_i ? fetch_enable_i : fetchen_q;
  assign boot_addr_o    = bootaddr_q;

endmodule

`default_nettype wire

//--- design/island_top.sv
// ---------------------------------------------------------------------
// Memory fabric of the safety island. Two bus managers reach two SRAM
// banks and a peripheral port through the crossbar; the peripheral port
// serves SoC control, boot ROM and the error responder. Boot address and
// fetch enable leave the island from the SoC control block.
// ---------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module island_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              mgr_req_i     [2],
  input  island_pkg::mem_req_t              mgr_payload_i [2],
  output logic                              mgr_gnt_o     [2],
  output logic                              mgr_rvalid_o  [2],
  output island_pkg::mem_rsp_t              mgr_rsp_o     [2],
  input  island_pkg::bootmode_e             bootmode_i,
  input  logic                              fetch_enable_selector_i,
  input  logic                              fetch_enable_i,
  output logic                              fetch_enable_o,
  output logic [island_pkg::addr_width-1:0] boot_addr_o
);

  // Crossbar target links
  logic                 tgt_req     [3];
  island_pkg::mem_req_t tgt_payload [3];
  logic                 tgt_gnt     [3];
  logic                 tgt_rvalid  [3];
  island_pkg::mem_rsp_t tgt_rsp     [3];

  // SoC control link
  logic                 soc_req;
  island_pkg::mem_req_t soc_payload;
  logic                 soc_gnt;
  logic                 soc_rvalid;
  island_pkg::mem_rsp_t soc_rsp;

  island_xbar i_xbar (
    .clk_i,
    .rst_ni,
    .mgr_req_i,
    .mgr_payload_i,
    .mgr_gnt_o,
    .mgr_rvalid_o,
    .mgr_rsp_o,
    .tgt_req_o     ( tgt_req     ),
    .tgt_payload_o ( tgt_payload ),
    .tgt_gnt_i     ( tgt_gnt     ),
    .tgt_rvalid_i  ( tgt_rvalid  ),
    .tgt_rsp_i     ( tgt_rsp     )
  );

  island_sram_bank i_bank0 (
    .clk_i,
    .rst_ni,
    .req_i     ( tgt_req[island_pkg::TGT_BANK0]     ),
    .payload_i ( tgt_payload[island_pkg::TGT_BANK0] ),
    .gnt_o     ( tgt_gnt[island_pkg::TGT_BANK0]     ),
    .rvalid_o  ( tgt_rvalid[island_pkg::TGT_BANK0]  ),
    .rsp_o     ( tgt_rsp[island_pkg::TGT_BANK0]     )
  );

  island_sram_bank i_bank1 (
    .clk_i,
    .rst_ni,
    .req_i     ( tgt_req[island_pkg::TGT_BANK1]     ),
    .payload_i ( tgt_payload[island_pkg::TGT_BANK1] ),
    .gnt_o     ( tgt_gnt[island_pkg::TGT_BANK1]     ),
    .rvalid_o  ( tgt_rvalid[island_pkg::TGT_BANK1]  ),
    .rsp_o     ( tgt_rsp[island_pkg::TGT_BANK1]     )
  );

  island_periph_demux i_periph_demux (
    .clk_i,
    .rst_ni,
    .req_i         ( tgt_req[island_pkg::TGT_PERIPH]     ),
    .payload_i     ( tgt_payload[island_pkg::TGT_PERIPH] ),
    .gnt_o         ( tgt_gnt[island_pkg::TGT_PERIPH]     ),
    .rvalid_o      ( tgt_rvalid[island_pkg::TGT_PERIPH]  ),
    .rsp_o         ( tgt_rsp[island_pkg::TGT_PERIPH]     ),
    .soc_req_o     ( soc_req     ),
    .soc_payload_o ( soc_payload ),
    .soc_gnt_i     ( soc_gnt     ),
    .soc_rvalid_i  ( soc_rvalid  ),
    .soc_rsp_i     ( soc_rsp     )
  );

  island_soc_ctrl i_soc_ctrl (
    .clk_i,
    .rst_ni,
    .req_i     ( soc_req     ),
    .payload_i ( soc_payload ),
    .gnt_o     ( soc_gnt     ),
    .rvalid_o  ( soc_rvalid  ),
    .rsp_o     ( soc_rsp     ),
    .bootmode_i,
    .fetch_enable_selector_i,
    .fetch_enable_i,
    .fetch_enable_o,
    .boot_addr_o
  );

endmodule

`default_nettype wire

//--- test/tb_island_top.sv
// ---------------------------------------------------------------------
// Testbench for the safety island memory fabric. A table of bus
// operations is built first and then applied row by row on either
// manager port. Reset state, the SoC control pins and a same-cycle
// collision on one bank are checked around the table.
// ---------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module tb_island_top;

  localparam int unsigned clk_period     = 40;
  localparam int unsigned timeout_cycles = 20;

  // One row of the stimulus table
  typedef struct packed {
    logic        mgr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;
    logic        exp_err;
    logic        chk_rdata;
  } op_t;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  mgr_req_i     [2];
  island_pkg::mem_req_t  mgr_payload_i [2];
  logic                  mgr_gnt_o     [2];
  logic                  mgr_rvalid_o  [2];
  island_pkg::mem_rsp_t  mgr_rsp_o     [2];
  island_pkg::bootmode_e bootmode_i;
  logic                  fetch_enable_selector_i;
  logic                  fetch_enable_i;
  logic                  fetch_enable_o;
  logic [31:0]           boot_addr_o;

  op_t         ops [$];
  string       op_names [$];
  logic [31:0] shadow [logic [31:0]];
  logic [31:0] lcg_state;
  logic [31:0] exp_boot_addr;
  bit          test_ok;
  bit          timed_out;
  int          n_tests;
  int          n_failed;

  island_top i_island_top (
    .clk_i,
    .rst_ni,
    .mgr_req_i,
    .mgr_payload_i,
    .mgr_gnt_o,
    .mgr_rvalid_o,
    .mgr_rsp_o,
    .bootmode_i,
    .fetch_enable_selector_i,
    .fetch_enable_i,
    .fetch_enable_o,
    .boot_addr_o
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Byte lanes with be set take the new data
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic add_op(input string name, input logic mgr, input logic we,
                        input logic [3:0] be, input logic [31:0] addr,
                        input logic [31:0] wdata, input logic [31:0] exp_rdata,
                        input logic exp_err, input logic chk_rdata);
    op_t op;
    op = {mgr, we, be, addr, wdata, exp_rdata, exp_err, chk_rdata};
    ops.push_back(op);
    op_names.push_back(name);
  endtask

  task automatic add_bank_write(input logic mgr, input logic [3:0] be, input logic [31:0] addr);
    logic [31:0] old_word;
    lcg_state = lcg_next(lcg_state);
    old_word  = shadow.exists(addr) ? shadow[addr] : 32'h0;
    shadow[addr] = merge_bytes(old_word, lcg_state, be);
    add_op($sformatf("bank write %08h be %b", addr, be), mgr, 1'b1, be, addr, lcg_state,
           32'h0, 1'b0, 1'b0);
  endtask

  task automatic add_bank_read(input logic mgr, input logic [31:0] addr);
    add_op($sformatf("bank read %08h mgr %0d", addr, mgr), mgr, 1'b0, 4'hf, addr, 32'h0,
           shadow[addr], 1'b0, 1'b1);
  endtask

  // ---------------------------------------------------------------------
  // Stimulus table
  // ---------------------------------------------------------------------
  task automatic build_table();
    logic [31:0] bank_addr [4];
    logic [3:0]  part_be [4];
    int          rom_word [6];
    logic [31:0] soc_base;
    logic [31:0] rom_base;
    bank_addr = '{32'h10, 32'h3fc, island_pkg::bank1_base + 32'h20,
                  island_pkg::bank1_base + 32'h3f0};
    part_be   = '{4'b0011, 4'b1100, 4'b0110, 4'b1000};
    rom_word  = '{0, 3, 7, 8, 13, 1023};
    soc_base  = island_pkg::periph_base + island_pkg::soc_ctrl_offset;
    rom_base  = island_pkg::periph_base + island_pkg::boot_rom_offset;
    // Full word first, then a partial write from the other manager
    for (int i = 0; i < 4; i++) begin
      add_bank_write(1'(i % 2), 4'hf, bank_addr[i]);
      add_bank_write(1'((i + 1) % 2), part_be[i], bank_addr[i]);
      add_bank_read(1'(i % 2), bank_addr[i]);
      add_bank_read(1'((i + 1) % 2), bank_addr[i]);
    end
    lcg_state     = lcg_next(lcg_state);
    exp_boot_addr = {lcg_state[31:2], 2'b00};
    add_op("BOOTADDR write", 1'b0, 1'b1, 4'hf, soc_base + island_pkg::reg_bootaddr_off,
           exp_boot_addr, 32'h0, 1'b0, 1'b0);
    add_op("BOOTADDR read", 1'b1, 1'b0, 4'hf, soc_base + island_pkg::reg_bootaddr_off,
           32'h0, exp_boot_addr, 1'b0, 1'b1);
    add_op("FETCHEN write", 1'b0, 1'b1, 4'h1, soc_base + island_pkg::reg_fetchen_off,
           32'h1, 32'h0, 1'b0, 1'b0);
    add_op("FETCHEN read", 1'b1, 1'b0, 4'hf, soc_base + island_pkg::reg_fetchen_off,
           32'h0, 32'h1, 1'b0, 1'b1);
    add_op("BOOTMODE read", 1'b0, 1'b0, 4'hf, soc_base + island_pkg::reg_bootmode_off,
           32'h0, 32'(island_pkg::BOOT_SERIAL), 1'b0, 1'b1);
    add_op("BOOTMODE write", 1'b1, 1'b1, 4'hf, soc_base + island_pkg::reg_bootmode_off,
           32'h2, 32'h0, 1'b1, 1'b0);
    add_op("unmapped SoC register", 1'b0, 1'b0, 4'hf, soc_base + 32'hc, 32'h0, 32'h0,
           1'b1, 1'b1);
    for (int i = 0; i < 6; i++) begin
      add_op($sformatf("boot ROM read word %0d", rom_word[i]), 1'(i % 2), 1'b0, 4'hf,
             rom_base + 32'(rom_word[i] * 4), 32'h0,
             island_pkg::boot_rom_words[rom_word[i] % 8], 1'b0, 1'b1);
    end
    add_op("boot ROM write", 1'b0, 1'b1, 4'hf, rom_base + 32'h8, 32'h1234_5678, 32'h0,
           1'b1, 1'b0);
    add_op("periph hole read", 1'b1, 1'b0, 4'hf, island_pkg::periph_base + 32'h2000, 32'h0,
           island_pkg::error_rdata, 1'b1, 1'b1);
    add_op("past bank 1 read", 1'b0, 1'b0, 4'hf,
           island_pkg::bank1_base + island_pkg::bank_num_bytes, 32'h0,
           island_pkg::error_rdata, 1'b1, 1'b1);
    add_op("below periph write", 1'b1, 1'b1, 4'hf, 32'h0010_0000, 32'h5555_aaaa,
           island_pkg::error_rdata, 1'b1, 1'b1);
  endtask

  // ---------------------------------------------------------------------
  // Checks and bus tasks
  // ---------------------------------------------------------------------
  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH at %0t: %s is %08h, expected %08h", $time, what, got, exp);
      test_ok = 1'b0;
    end
  endtask

  task automatic finish_test(input string name);
    n_tests++;
    if (!test_ok) begin
      n_failed++;
    end
    $display("test %0d %s: %s", n_tests, name, test_ok ? "ok" : "FAIL");
  endtask

  task automatic run_op(input op_t op, input string name);
    int                   cycles;
    int                   lat;
    bit                   granted;
    bit                   seen;
    island_pkg::mem_rsp_t rsp;
    test_ok = 1'b1;
    @(negedge clk_i);
    mgr_req_i[op.mgr]     = 1'b1;
    mgr_payload_i[op.mgr] = {op.we, op.be, op.addr, op.wdata};
    cycles  = 0;
    granted = 1'b0;
    while (!granted && cycles < timeout_cycles) begin
      @(posedge clk_i);
      granted = mgr_gnt_o[op.mgr];
      cycles++;
    end
    if (!granted) begin
      $display("%0t: %s got no grant within %0d cycles", $time, name, timeout_cycles);
      timed_out = 1'b1;
      test_ok   = 1'b0;
    end else begin
      lat  = 0;
      seen = 1'b0;
      while (!seen && lat < timeout_cycles) begin
        @(negedge clk_i);
        mgr_req_i[op.mgr] = 1'b0;
        lat++;
        seen = mgr_rvalid_o[op.mgr];
      end
      rsp = mgr_rsp_o[op.mgr];
      assert (seen && lat == 1) else begin
        $display("%0t: %s response did not come one cycle after the grant", $time, name);
        test_ok = 1'b0;
      end
      if (!seen) begin
        timed_out = 1'b1;
      end else begin
        check_value({name, " err"}, {31'b0, rsp.err}, {31'b0, op.exp_err});
        if (op.chk_rdata) begin
          check_value({name, " rdata"}, rsp.rdata, op.exp_rdata);
        end
      end
    end
    mgr_req_i[op.mgr] = 1'b0;
    finish_test(name);
  endtask

  task automatic check_reset_state();
    test_ok = 1'b1;
    check_value("boot_addr_o", boot_addr_o, island_pkg::boot_addr_default);
    check_value("fetch_enable_o", {31'b0, fetch_enable_o}, 32'h0);
    check_value("manager 0 rvalid", {31'b0, mgr_rvalid_o[0]}, 32'h0);
    check_value("manager 1 rvalid", {31'b0, mgr_rvalid_o[1]}, 32'h0);
    finish_test("state after reset");
  endtask

  task automatic check_soc_pins();
    test_ok = 1'b1;
    @(negedge clk_i);
    check_value("boot_addr_o", boot_addr_o, exp_boot_addr);
    check_value("fetch_enable_o from register", {31'b0, fetch_enable_o}, 32'h1);
    fetch_enable_selector_i = 1'b1;
    fetch_enable_i          = 1'b0;
    @(negedge clk_i);
    check_value("fetch_enable_o from pin low", {31'b0, fetch_enable_o}, 32'h0);
    fetch_enable_i = 1'b1;
    @(negedge clk_i);
    check_value("fetch_enable_o from pin high", {31'b0, fetch_enable_o}, 32'h1);
    fetch_enable_selector_i = 1'b0;
    fetch_enable_i          = 1'b0;
    finish_test("soc control pins");
  endtask

  // Both managers write one bank word in the same cycle
  task automatic check_contention();
    logic [31:0] data [2];
    int          gnt_cyc [2];
    int          rsp_cyc [2];
    logic        order [$];
    int          cyc;
    op_t         op;
    test_ok = 1'b1;
    @(negedge clk_i);
    for (int m = 0; m < 2; m++) begin
      lcg_state        = lcg_next(lcg_state);
      data[m]          = lcg_state;
      gnt_cyc[m]       = -1;
      rsp_cyc[m]       = -1;
      mgr_req_i[m]     = 1'b1;
      mgr_payload_i[m] = {1'b1, 4'hf, 32'h40, data[m]};
    end
    cyc = 0;
    while ((rsp_cyc[0] < 0 || rsp_cyc[1] < 0) && cyc < timeout_cycles) begin
      @(posedge clk_i);
      for (int m = 0; m < 2; m++) begin
        if (mgr_req_i[m] && mgr_gnt_o[m]) begin
          gnt_cyc[m] = cyc;
          order.push_back(1'(m));
        end
      end
      cyc++;
      @(negedge clk_i);
      for (int m = 0; m < 2; m++) begin
        if (gnt_cyc[m] >= 0) begin
          mgr_req_i[m] = 1'b0;
        end
        if (mgr_rvalid_o[m] && rsp_cyc[m] < 0) begin
          rsp_cyc[m] = cyc;
        end
      end
    end
    if (rsp_cyc[0] < 0 || rsp_cyc[1] < 0 || order.size() != 2) begin
      $display("%0t: colliding writes did not both complete in %0d cycles", $time, cyc);
      timed_out = 1'b1;
      test_ok   = 1'b0;
    end else begin
      assert (gnt_cyc[0] != gnt_cyc[1]) else begin
        $display("%0t: both managers were granted the same bank in one cycle", $time);
        test_ok = 1'b0;
      end
      for (int m = 0; m < 2; m++) begin
        assert (rsp_cyc[m] == gnt_cyc[m] + 1) else begin
          $display("%0t: manager %0d response was not one cycle after its grant", $time, m);
          test_ok = 1'b0;
        end
      end
    end
    mgr_req_i[0] = 1'b0;
    mgr_req_i[1] = 1'b0;
    finish_test("bank contention");
    if (!timed_out) begin
      op = {1'b0, 1'b0, 4'hf, 32'h40, 32'h0, data[order[1]], 1'b0, 1'b1};
      run_op(op, "contention read-back");
    end
  endtask

  // ---------------------------------------------------------------------
  // Main sequence
  // ---------------------------------------------------------------------
  initial begin
    rst_ni                  = 1'b0;
    bootmode_i              = island_pkg::BOOT_SERIAL;
    fetch_enable_selector_i = 1'b0;
    fetch_enable_i          = 1'b0;
    for (int m = 0; m < 2; m++) begin
      mgr_req_i[m]     = 1'b0;
      mgr_payload_i[m] = '0;
    end
    lcg_state = 32'h8f4f;
    timed_out = 1'b0;
    n_tests   = 0;
    n_failed  = 0;
    build_table();
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_reset_state();
    for (int i = 0; i < ops.size() && !timed_out; i++) begin
      run_op(ops[i], op_names[i]);
    end
    if (!timed_out) begin
      check_soc_pins();
    end
    if (!timed_out) begin
      check_contention();
    end
    if (timed_out) begin
      $display("run stopped early after a bus timeout");
    end
    $display("tests: %0d, passed: %0d, failed: %0d", n_tests, n_tests - n_failed, n_failed);
    if (n_failed == 0 && !timed_out) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
design/island_pkg.sv
design/island_xbar.sv
design/island_sram_bank.sv
design/island_periph_demux.sv
design/island_soc_ctrl.sv
design/island_top.sv
test/tb_island_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for failure

cd "$(dirname "$0")" &&
  verilator --binary --assert -f sources.f --top-module tb_island_top > build.log 2>&1 &&
  ./obj_dir/Vtb_island_top > sim.log 2>&1 &&
  ! grep -qF '*** FAILED ***' sim.log &&
  echo "simulation passed" ||
  { echo "simulation failed, see build.log and sim.log"; exit 1; }
